/* src/tx_status_defines.svh */
// Register offsets are byte addresses on an 8-bit APB bus; the count width must hold FIFO depth
`ifndef TX_STATUS_DEFINES_SVH
`define TX_STATUS_DEFINES_SVH

// Records held per queue
`define TXS_FIFO_DEPTH 64

// Occupancy and drop counter width, wide enough for a full queue
`define TXS_CNT_W 7

// Info record, first word; reading it does not pop
`define TXS_ADDR_INFO1 8'h58
// Info record, second word; reading it pops the info queue
`define TXS_ADDR_INFO2 8'h5C

// Block-ack bitmap, low half; reading it does not pop
`define TXS_ADDR_BMP_LO 8'h60
// Block-ack bitmap, high half; reading it pops the bitmap queue
`define TXS_ADDR_BMP_HI 8'h64

// Info occupancy in bits 7:0, drop counter in bits 15:8
`define TXS_ADDR_STAT 8'h68

`endif

/* src/tx_status_pkg.sv */
// Record types for the transmit status queues; field widths are fixed by the register layout
`default_nettype none

`include "tx_status_defines.svh"

package tx_status_pkg;

    // One completed transmit attempt, without the bitmap
    typedef struct packed {
        logic [3:0]  cw_adj;    // Contention window with slot carry
        logic [8:0]  slots;     // Random backoff slots
        logic [1:0]  prio;      // Linux priority
        logic [1:0]  queue_idx; // Hardware queue
        logic [5:0]  bd_idx;    // Buffer descriptor index
        logic [3:0]  retrans;   // Retransmission count
        logic [11:0] ssn;       // Block-ack start sequence number
        logic [5:0]  pkt_cnt;   // Packets in the aggregate
    } tx_info_t;

    // Block-ack bitmap, bit 0 is the SSN frame
    typedef logic [63:0] ba_bitmap_t;

    // Occupancy and drop counters
    typedef logic [`TXS_CNT_W-1:0] txs_cnt_t;

endpackage

`default_nettype wire

/* src/status_queue_if.sv */
// Queue heads are first-word-fall-through; a pop is only legal while the queue is not empty
`default_nettype none

interface status_queue_if
    import tx_status_pkg::*;
();

    tx_info_t   info_head;   // Oldest info record
    logic       info_empty;
    logic       info_pop;
    ba_bitmap_t bitmap_head; // Oldest bitmap
    logic       bitmap_empty;
    logic       bitmap_pop;
    txs_cnt_t   info_count;  // Records in the info queue
    txs_cnt_t   drop_cnt;    // Records lost to a full queue
    logic       drop_clr;

    modport queue (
        output info_head, info_empty, bitmap_head, bitmap_empty, info_count, drop_cnt,
        input  info_pop, bitmap_pop, drop_clr
    );

    modport apb (
        input  info_head, info_empty, bitmap_head, bitmap_empty, info_count, drop_cnt,
        output info_pop, bitmap_pop, drop_clr
    );

endinterface

`default_nettype wire

/* src/tx_status_capture.sv */
// All fields must be valid in the same cycle as tx_try_complete; there is no back-pressure
`default_nettype none

module tx_status_capture
    import tx_status_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        tx_try_complete,
    input  wire logic [9:0]  num_slot_random,
    input  wire logic [3:0]  cw,
    input  wire logic [79:0] tx_status,
    input  wire logic [1:0]  linux_prio,
    input  wire logic [5:0]  pkt_cnt,
    input  wire logic [1:0]  tx_queue_idx,
    input  wire logic [5:0]  bd_wr_idx,
    output tx_info_t         rec_info,
    output ba_bitmap_t       rec_bitmap,
    output logic             rec_valid
);

    tx_info_t info_d;

    // Pack the status word and side fields into one record
    always_comb begin
        info_d.cw_adj    = cw + 4'(num_slot_random[9]); // Window grows on slot carry
        info_d.slots     = num_slot_random[8:0];
        info_d.prio      = linux_prio;
        info_d.queue_idx = tx_queue_idx;
        info_d.bd_idx    = bd_wr_idx;
        info_d.retrans   = tx_status[3:0];
        info_d.ssn       = tx_status[15:4];
        info_d.pkt_cnt   = pkt_cnt;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= tx_try_complete;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_try_complete) begin
            rec_info   <= info_d;
            rec_bitmap <= tx_status[79:16]; // Upper 64 bits carry the bitmap
        end
    end

endmodule

`default_nettype wire

/* src/sync_fifo.sv */
// Single clock only; count width must cover DEPTH, writes when full and reads when empty are lost
`default_nettype none

`include "tx_status_defines.svh"

module sync_fifo
    import tx_status_pkg::*;
#(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `TXS_FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     wr_en,
    input  wire payload_t wr_data,
    input  wire logic     rd_en,
    output payload_t      rd_data,
    output logic          empty,
    output logic          full,
    output txs_cnt_t      count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            wr_ok;
    logic            rd_ok;

    assign empty   = (count == '0);
    assign full    = (count == txs_cnt_t'(DEPTH));
    assign wr_ok   = wr_en && !full;
    assign rd_ok   = rd_en && !empty;
    assign rd_data = mem[rd_ptr]; // Head is visible without a read

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* src/tx_status_queue.sv */
// A record is kept only if both queues have room; the drop counter saturates until cleared
`default_nettype none

`include "tx_status_defines.svh"

module tx_status_queue
    import tx_status_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       rec_valid,
    input  wire tx_info_t   rec_info,
    input  wire ba_bitmap_t rec_bitmap,
    status_queue_if.queue   sq
);

    logic info_full;
    logic bitmap_full;
    logic rec_wr;
    logic rec_drop;

    // Both halves of a record go in together or not at all
    assign rec_wr   = rec_valid && !info_full && !bitmap_full;
    assign rec_drop = rec_valid && (info_full || bitmap_full);

    sync_fifo #(
        .payload_t (tx_info_t),
        .DEPTH     (`TXS_FIFO_DEPTH)
    ) u_info_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (rec_wr),
        .wr_data (rec_info),
        .rd_en   (sq.info_pop),
        .rd_data (sq.info_head),
        .empty   (sq.info_empty),
        .full    (info_full),
        .count   (sq.info_count)
    );

    sync_fifo #(
        .payload_t (ba_bitmap_t),
        .DEPTH     (`TXS_FIFO_DEPTH)
    ) u_bitmap_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (rec_wr),
        .wr_data (rec_bitmap),
        .rd_en   (sq.bitmap_pop),
        .rd_data (sq.bitmap_head),
        .empty   (sq.bitmap_empty),
        .full    (bitmap_full),
        .count   () // Tracks the info queue when read in pairs
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sq.drop_cnt <= '0;
        end else if (sq.drop_clr) begin
            sq.drop_cnt <= '0; // Clear wins over a same-cycle drop
        end else if (rec_drop && (sq.drop_cnt != '1)) begin
            sq.drop_cnt <= sq.drop_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/tx_status_apb.sv */
// No wait states; write data is not used, any write to STAT clears the drop counter
`default_nettype none

`include "tx_status_defines.svh"

module tx_status_apb
    import tx_status_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic [7:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    status_queue_if.apb      sq
);

    logic access;
    logic rd_access;
    logic addr_hit;

    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign pready    = 1'b1;

    always_comb begin
        case (paddr)
            `TXS_ADDR_INFO1, `TXS_ADDR_INFO2, `TXS_ADDR_BMP_LO,
            `TXS_ADDR_BMP_HI, `TXS_ADDR_STAT: addr_hit = 1'b1;
            default:                          addr_hit = 1'b0;
        endcase
    end

    // Read words, with the empty values substituted
    always_comb begin
        case (paddr)
            `TXS_ADDR_INFO1: begin
                prdata = sq.info_empty ? 32'hFFFF_FFFF :
                         {sq.info_head.cw_adj, sq.info_head.slots, sq.info_head.prio,
                          sq.info_head.queue_idx, 4'd0, sq.info_head.bd_idx, 1'b0,
                          sq.info_head.retrans};
            end
            `TXS_ADDR_INFO2: begin
                prdata = sq.info_empty ? 32'd0 :
                         {14'd0, sq.info_head.ssn, sq.info_head.pkt_cnt};
            end
            `TXS_ADDR_BMP_LO: prdata = sq.bitmap_empty ? 32'd0 : sq.bitmap_head[31:0];
            `TXS_ADDR_BMP_HI: prdata = sq.bitmap_empty ? 32'd0 : sq.bitmap_head[63:32];
            `TXS_ADDR_STAT:   prdata = {16'd0, 8'(sq.drop_cnt), 8'(sq.info_count)};
            default:          prdata = 32'd0;
        endcase
    end

    // Second word of each pair advances its queue
    assign sq.info_pop   = rd_access && (paddr == `TXS_ADDR_INFO2) && !sq.info_empty;
    assign sq.bitmap_pop = rd_access && (paddr == `TXS_ADDR_BMP_HI) && !sq.bitmap_empty;
    assign sq.drop_clr   = access && pwrite && (paddr == `TXS_ADDR_STAT);

    // Decoded in the setup phase, held through the access phase
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pslverr <= 1'b0;
        end else if (psel && !penable) begin
            pslverr <= !addr_hit;
        end else begin
            pslverr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/tx_status_top.sv */
// Single clock domain; capture fields must be stable with the strobe, APB has no wait states
`default_nettype none

module tx_status_top
    import tx_status_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        tx_try_complete,
    input  wire logic [9:0]  num_slot_random,
    input  wire logic [3:0]  cw,
    input  wire logic [79:0] tx_status,
    input  wire logic [1:0]  linux_prio,
    input  wire logic [5:0]  pkt_cnt,
    input  wire logic [1:0]  tx_queue_idx,
    input  wire logic [5:0]  bd_wr_idx,
    input  wire logic [7:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr
);

    logic       rec_valid;
    tx_info_t   rec_info;
    ba_bitmap_t rec_bitmap;

    status_queue_if sq_if ();

    tx_status_capture u_capture (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .num_slot_random (num_slot_random),
        .cw              (cw),
        .tx_status       (tx_status),
        .linux_prio      (linux_prio),
        .pkt_cnt         (pkt_cnt),
        .tx_queue_idx    (tx_queue_idx),
        .bd_wr_idx       (bd_wr_idx),
        .rec_info        (rec_info),
        .rec_bitmap      (rec_bitmap),
        .rec_valid       (rec_valid)
    );

    tx_status_queue u_queue (
        .clk        (clk),
        .rstn       (rstn),
        .rec_valid  (rec_valid),
        .rec_info   (rec_info),
        .rec_bitmap (rec_bitmap),
        .sq         (sq_if.queue)
    );

    tx_status_apb u_apb (
        .clk     (clk),
        .rstn    (rstn),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sq      (sq_if.apb)
    );

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
// Free-running clock from time zero; reset releases on a rising edge after RESET_CYCLES
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1; // Released with the other stimulus
    end

endmodule

`default_nettype wire

/* sim/tb_tx_status.sv */
// APB accesses run back to back and need bus_idle before strobes; outputs sampled on falling edges
`default_nettype none

`include "tx_status_defines.svh"

module tb_tx_status
    import tx_status_pkg::*;
();

    localparam int N_ENTRIES = 32;
    localparam int LIMIT     = N_ENTRIES * 20 + 500; // Cycle budget for the whole run
    localparam int N_FLOOD   = 70;

    typedef struct packed {
        logic [9:0]  nsr;
        logic [3:0]  cw;
        logic [79:0] status;
        logic [1:0]  prio;
        logic [5:0]  pkt;
        logic [1:0]  qidx;
        logic [5:0]  bd;
        tx_info_t    exp_info;
        ba_bitmap_t  exp_bmp;
    } entry_t;

    logic        clk;
    logic        rstn;
    logic        tx_try_complete;
    logic [9:0]  num_slot_random;
    logic [3:0]  cw;
    logic [79:0] tx_status;
    logic [1:0]  linux_prio;
    logic [5:0]  pkt_cnt;
    logic [1:0]  tx_queue_idx;
    logic [5:0]  bd_wr_idx;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    entry_t tbl [N_ENTRIES];
    int     errors       = 0;
    int     checks       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     test_err0    = 0;
    int     cycles       = 0;

    tb_clkgen #(.PERIOD(20), .RESET_CYCLES(5)) u_clkgen (.clk(clk), .rstn(rstn));

    tx_status_top UUT (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .num_slot_random (num_slot_random),
        .cw              (cw),
        .tx_status       (tx_status),
        .linux_prio      (linux_prio),
        .pkt_cnt         (pkt_cnt),
        .tx_queue_idx    (tx_queue_idx),
        .bd_wr_idx       (bd_wr_idx),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_info(input tx_info_t got, input tx_info_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s info got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bitmap(input ba_bitmap_t got, input ba_bitmap_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s bitmap got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cnt(input txs_cnt_t got, input txs_cnt_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Leaves the bus in the access phase so the next transfer follows directly
    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        checks++;
        if (pready !== 1'b1) begin
            errors++;
            $display("pready was low in the access phase to address %h at %0t", addr, $time);
        end
    endtask

    task automatic bus_idle;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(addr, 1'b0, 32'd0, rdata, err);
        checks++;
        if (err !== 1'b0) begin
            errors++;
            $display("pslverr was set on a read of mapped address %h at %0t", addr, $time);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        logic        err;
        apb_xfer(addr, 1'b1, wdata, unused, err);
        checks++;
        if (err !== 1'b0) begin
            errors++;
            $display("pslverr was set on a write to mapped address %h at %0t", addr, $time);
        end
    endtask

    // Field positions follow the register layout of INFO1 and INFO2
    function automatic tx_info_t words_to_info(input logic [31:0] w1, input logic [31:0] w2);
        tx_info_t r;
        r.cw_adj    = w1[31:28];
        r.slots     = w1[27:19];
        r.prio      = w1[18:17];
        r.queue_idx = w1[16:15];
        r.bd_idx    = w1[10:5];
        r.retrans   = w1[3:0];
        r.ssn       = w2[17:6];
        r.pkt_cnt   = w2[5:0];
        return r;
    endfunction

    task automatic read_record(input tx_info_t exp_info, input ba_bitmap_t exp_bmp,
                               input string tag);
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] lo;
        logic [31:0] hi;
        read_reg(`TXS_ADDR_INFO1, w1);
        read_reg(`TXS_ADDR_INFO2, w2); // Pops the info queue
        read_reg(`TXS_ADDR_BMP_LO, lo);
        read_reg(`TXS_ADDR_BMP_HI, hi); // Pops the bitmap queue
        check_word(w1 & 32'h0000_7810, 32'd0, {tag, " INFO1 zero bits"});
        check_word(w2 & 32'hFFFC_0000, 32'd0, {tag, " INFO2 zero bits"});
        check_info(words_to_info(w1, w2), exp_info, tag);
        check_bitmap({hi, lo}, exp_bmp, tag);
    endtask

    task automatic check_stat(input txs_cnt_t exp_cnt, input txs_cnt_t exp_drop,
                              input string tag);
        logic [31:0] w;
        read_reg(`TXS_ADDR_STAT, w);
        check_cnt(txs_cnt_t'(w[7:0]), exp_cnt, {tag, " info_count"});
        check_cnt(txs_cnt_t'(w[15:8]), exp_drop, {tag, " drop_cnt"});
    endtask

    task automatic send_entry(input int idx);
        @(posedge clk);
        tx_try_complete <= 1'b1;
        num_slot_random <= tbl[idx].nsr;
        cw              <= tbl[idx].cw;
        tx_status       <= tbl[idx].status;
        linux_prio      <= tbl[idx].prio;
        pkt_cnt         <= tbl[idx].pkt;
        tx_queue_idx    <= tbl[idx].qidx;
        bd_wr_idx       <= tbl[idx].bd;
    endtask

    // Two cycles of pipeline latency plus the strobe edge itself
    task automatic end_strobes;
        @(posedge clk);
        tx_try_complete <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_err0);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        test_err0 = errors;
    endtask

    task automatic fill_table;
        for (int i = 0; i < N_ENTRIES; i++) begin
            tbl[i].nsr    = 10'($urandom);
            tbl[i].cw     = 4'($urandom);
            tbl[i].status = {16'($urandom), $urandom, $urandom};
            tbl[i].prio   = 2'($urandom);
            tbl[i].pkt    = 6'($urandom);
            tbl[i].qidx   = 2'($urandom);
            tbl[i].bd     = 6'($urandom);
            tbl[i].exp_info.cw_adj    = tbl[i].cw + 4'(tbl[i].nsr[9]); // Carry from slot count
            tbl[i].exp_info.slots     = tbl[i].nsr[8:0];
            tbl[i].exp_info.prio      = tbl[i].prio;
            tbl[i].exp_info.queue_idx = tbl[i].qidx;
            tbl[i].exp_info.bd_idx    = tbl[i].bd;
            tbl[i].exp_info.retrans   = tbl[i].status[3:0];
            tbl[i].exp_info.ssn       = tbl[i].status[15:4];
            tbl[i].exp_info.pkt_cnt   = tbl[i].pkt;
            tbl[i].exp_bmp            = tbl[i].status[79:16];
        end
    endtask

    initial begin
        logic [31:0] w;
        logic        err;
        tx_info_t    e;
        void'($urandom(8531));
        tx_try_complete = 1'b0;
        num_slot_random = '0;
        cw              = '0;
        tx_status       = '0;
        linux_prio      = '0;
        pkt_cnt         = '0;
        tx_queue_idx    = '0;
        bd_wr_idx       = '0;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        fill_table();
        wait (rstn === 1'b1);

        read_reg(`TXS_ADDR_INFO1, w);
        check_word(w, 32'hFFFF_FFFF, "empty INFO1");
        read_reg(`TXS_ADDR_INFO2, w);
        check_word(w, 32'd0, "empty INFO2");
        read_reg(`TXS_ADDR_BMP_LO, w);
        check_word(w, 32'd0, "empty BMP_LO");
        read_reg(`TXS_ADDR_BMP_HI, w);
        check_word(w, 32'd0, "empty BMP_HI");
        read_reg(`TXS_ADDR_STAT, w);
        check_word(w, 32'd0, "idle STAT");
        bus_idle();
        end_test("reset values");

        for (int i = 0; i < N_ENTRIES; i++) begin
            send_entry(i);
        end
        end_strobes();
        check_stat(N_ENTRIES, 0, "after fill");
        for (int i = 0; i < N_ENTRIES; i++) begin
            read_record(tbl[i].exp_info, tbl[i].exp_bmp, $sformatf("record %0d", i));
            check_stat(txs_cnt_t'(N_ENTRIES - 1 - i), 0, $sformatf("after pop %0d", i));
        end
        bus_idle();
        end_test("ordered read-out");

        bus_idle();
        send_entry(0);
        end_strobes();
        e = tbl[0].exp_info;
        repeat (3) begin
            read_reg(`TXS_ADDR_INFO1, w);
            check_word(w, {e.cw_adj, e.slots, e.prio, e.queue_idx, 4'd0, e.bd_idx, 1'b0,
                           e.retrans}, "repeated INFO1");
            read_reg(`TXS_ADDR_BMP_LO, w);
            check_word(w, tbl[0].exp_bmp[31:0], "repeated BMP_LO");
        end
        read_record(e, tbl[0].exp_bmp, "peeked record");
        check_stat(0, 0, "after peek");
        bus_idle();
        end_test("non-popping reads");

        // Period of 31 so the dropped records differ from the ones they would overwrite
        for (int i = 0; i < N_FLOOD; i++) begin
            send_entry(i % (N_ENTRIES - 1));
        end
        end_strobes();
        check_stat(`TXS_FIFO_DEPTH, N_FLOOD - `TXS_FIFO_DEPTH, "after flood");
        for (int i = 0; i < `TXS_FIFO_DEPTH; i++) begin
            read_record(tbl[i % (N_ENTRIES - 1)].exp_info, tbl[i % (N_ENTRIES - 1)].exp_bmp,
                        $sformatf("flood record %0d", i));
        end
        check_stat(0, N_FLOOD - `TXS_FIFO_DEPTH, "after drain");
        write_reg(`TXS_ADDR_STAT, 32'd0);
        check_stat(0, 0, "after clear");
        bus_idle();
        end_test("overflow and drop counter");

        apb_xfer(8'h00, 1'b0, 32'd0, w, err);
        checks++;
        if (err !== 1'b1) begin
            errors++;
            $display("pslverr stayed low on a read of unmapped address 00 at %0t", $time);
        end
        apb_xfer(8'h6C, 1'b1, 32'hA5A5_A5A5, w, err);
        checks++;
        if (err !== 1'b1) begin
            errors++;
            $display("pslverr stayed low on a write to unmapped address 6C at %0t", $time);
        end
        check_stat(0, 0, "after unmapped accesses");
        bus_idle();
        end_test("unmapped addresses");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/tx_status_pkg.sv
src/status_queue_if.sv
src/tx_status_capture.sv
src/sync_fifo.sv
src/tx_status_queue.sv
src/tx_status_apb.sv
src/tx_status_top.sv
sim/tb_clkgen.sv
sim/tb_tx_status.sv

/* Bender.yml */
package:
  name: tx_status

sources:
  - include_dirs:
      - src
    files:
      - src/tx_status_pkg.sv
      - src/status_queue_if.sv
      - src/tx_status_capture.sv
      - src/sync_fifo.sv
      - src/tx_status_queue.sv
      - src/tx_status_apb.sv
      - src/tx_status_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clkgen.sv
      - sim/tb_tx_status.sv
